/* include/aipCoprocessor_params.svh */
`ifndef AIP_COPROCESSOR_PARAMS_SVH
`define AIP_COPROCESSOR_PARAMS_SVH

`define AIP_DATA_WIDTH 32 // bus word width

`define AIP_CONFIG_WIDTH 5 // config code width

`define AIP_MEM_ADDR_WIDTH 7 // 128 words per buffer

`define AIP_MEM_DEPTH (1 << `AIP_MEM_ADDR_WIDTH)

`define AIP_IP_ID 32'h00004003 // ip-core identity

`endif

/* hdl/aipPkg.sv */
`default_nettype none
`include "aipCoprocessor_params.svh"

package aipPkg;

  typedef enum logic [`AIP_CONFIG_WIDTH-1:0] {
    CFG_BUF_DATA  = 5'd0, // own buffer data
    CFG_BUF_ADDR  = 5'd1, // load write pointer
    CFG_PEER_DATA = 5'd2, // peer buffer data
    CFG_PEER_ADDR = 5'd3, // load read pointer
    CFG_STATUS    = 5'd30,
    CFG_ID        = 5'd31
  } configCode_t;

  // same word seen as a bus value or as status fields
  typedef union packed {
    logic [`AIP_DATA_WIDTH-1:0] raw;
    struct packed {
      logic [15:0] reserved;
      logic [7:0]  statusCode;
      logic [7:0]  intFlags; // one bit per interrupt source
    } fields;
  } statusWord_t;

endpackage

`default_nettype wire

/* hdl/aipBufIf.sv */
`default_nettype none
`include "aipCoprocessor_params.svh"

interface aipBufIf;

  logic                           wrEn;
  logic [`AIP_MEM_ADDR_WIDTH-1:0] wrAddr;
  logic [`AIP_DATA_WIDTH-1:0]     wrData;
  logic [`AIP_MEM_ADDR_WIDTH-1:0] rdAddr;
  logic [`AIP_DATA_WIDTH-1:0]     rdData;

  modport writer (output wrEn, output wrAddr, output wrData);

  modport reader (output rdAddr, input rdData);

  modport ram (
    input  wrEn, wrAddr, wrData, rdAddr,
    output rdData
  );

endinterface

`default_nettype wire

/* hdl/aipDualPortRam.sv */
`default_nettype none
`include "aipCoprocessor_params.svh"

module aipDualPortRam (
  input wire clk,
  aipBufIf.ram mem
);

  logic [`AIP_DATA_WIDTH-1:0] memory [0:`AIP_MEM_DEPTH-1];

  // single write port, stored on the rising edge
  always_ff @(posedge clk) begin
    if (mem.wrEn) begin
      memory[mem.wrAddr] <= mem.wrData;
    end
  end

  // asynchronous read, zero latency
  assign mem.rdData = memory[mem.rdAddr];

endmodule

`default_nettype wire

/* hdl/aipPortCtrl.sv */
`default_nettype none
`include "aipCoprocessor_params.svh"

module aipPortCtrl
  import aipPkg::*;
(
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        en_i,
  input  wire                        read_i,
  input  wire                        write_i,
  input  configCode_t                config_i,
  input  wire [`AIP_DATA_WIDTH-1:0]  dataIn_i,
  input  statusWord_t                status_i,
  aipBufIf.writer                    wrBuf,
  aipBufIf.reader                    rdBuf,
  output logic                       setStatus_o,
  output logic [`AIP_DATA_WIDTH-1:0] dataOut_o
);

  logic [`AIP_MEM_ADDR_WIDTH-1:0] wrPtr; // next word written to own buffer
  logic [`AIP_MEM_ADDR_WIDTH-1:0] rdPtr; // next word read from peer buffer
  logic                           bufWrite;
  logic                           wrPtrLoad;
  logic                           rdPtrLoad;
  logic                           peerRead;

  // code decode
  assign bufWrite    = write_i && (config_i == CFG_BUF_DATA);
  assign wrPtrLoad   = write_i && (config_i == CFG_BUF_ADDR);
  assign rdPtrLoad   = write_i && (config_i == CFG_PEER_ADDR);
  assign peerRead    = read_i && (config_i == CFG_PEER_DATA);
  assign setStatus_o = write_i && (config_i == CFG_STATUS);

  // own buffer write port
  assign wrBuf.wrEn   = bufWrite; // store is not held off by en_i
  assign wrBuf.wrAddr = wrPtr;
  assign wrBuf.wrData = dataIn_i;

  // peer buffer read port
  assign rdBuf.rdAddr = rdPtr;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      wrPtr <= '0;
    end else if (en_i) begin
      if (wrPtrLoad) begin
        wrPtr <= dataIn_i[`AIP_MEM_ADDR_WIDTH-1:0];
      end else if (bufWrite) begin
        wrPtr <= wrPtr + 1'b1; // wraps at buffer end
      end
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      rdPtr <= '0;
    end else if (en_i) begin
      if (rdPtrLoad) begin
        rdPtr <= dataIn_i[`AIP_MEM_ADDR_WIDTH-1:0];
      end else if (peerRead) begin
        rdPtr <= rdPtr + 1'b1; // advance after the read cycle
      end
    end
  end

  // readback mux, combinational from code and pointer
  always_comb begin
    case (config_i)
      CFG_PEER_DATA: dataOut_o = rdBuf.rdData;
      CFG_STATUS:    dataOut_o = status_i.raw;
      CFG_ID:        dataOut_o = `AIP_IP_ID;
      default:       dataOut_o = '0; // unknown codes read zero
    endcase
  end

endmodule

`default_nettype wire

/* hdl/aipStatus.sv */
`default_nettype none
`include "aipCoprocessor_params.svh"

module aipStatus
  import aipPkg::*;
(
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       setUp_i,
  input  wire                       clearNet_i,
  input  wire [`AIP_DATA_WIDTH-1:0] upData_i,
  input  wire [`AIP_DATA_WIDTH-1:0] netData_i,
  output statusWord_t               status_o,
  output logic                      intReq_o
);

  statusWord_t upWord;
  statusWord_t netWord;
  statusWord_t readback;
  logic [7:0]  statusCode;
  logic [7:0]  intFlags; // pending interrupts

  assign upWord.raw  = upData_i;
  assign netWord.raw = netData_i;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      statusCode <= '0;
      intFlags   <= '0;
    end else if (setUp_i) begin
      // uP set takes priority over a network clear in the same cycle
      statusCode <= upWord.fields.statusCode;
      intFlags   <= intFlags | upWord.fields.intFlags;
    end else if (clearNet_i) begin
      intFlags <= intFlags & ~netWord.fields.intFlags; // write one to clear
    end
  end

  always_comb begin
    readback.fields.reserved   = '0;
    readback.fields.statusCode = statusCode;
    readback.fields.intFlags   = intFlags;
  end

  assign status_o = readback;
  assign intReq_o = |intFlags; // any pending flag

endmodule

`default_nettype wire

/* hdl/aipCoprocessor.sv */
`default_nettype none
`include "aipCoprocessor_params.svh"

module aipCoprocessor
  import aipPkg::*;
(
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         en_i,
  // network side
  input  wire [`AIP_DATA_WIDTH-1:0]   dataInNet_i,
  input  wire [`AIP_CONFIG_WIDTH-1:0] configNet_i,
  input  wire                         readNet_i,
  input  wire                         writeNet_i,
  output wire [`AIP_DATA_WIDTH-1:0]   dataOutNet_o,
  output wire                         intNet_o,
  // uP side
  input  wire [`AIP_DATA_WIDTH-1:0]   dataInUp_i,
  input  wire [`AIP_CONFIG_WIDTH-1:0] configUp_i,
  input  wire                         readUp_i,
  input  wire                         writeUp_i,
  output wire [`AIP_DATA_WIDTH-1:0]   dataOutUp_o
);

  statusWord_t statusWord;
  wire         setStatusNet; // network clear strobe
  wire         setStatusUp; // uP set strobe

  aipBufIf inBuf (); // network to uP
  aipBufIf outBuf (); // uP to network

  aipPortCtrl netCtrl (
    .clk         (clk),
    .rst         (rst),
    .en_i        (en_i),
    .read_i      (readNet_i),
    .write_i     (writeNet_i),
    .config_i    (configCode_t'(configNet_i)),
    .dataIn_i    (dataInNet_i),
    .status_i    (statusWord),
    .wrBuf       (inBuf.writer),
    .rdBuf       (outBuf.reader),
    .setStatus_o (setStatusNet),
    .dataOut_o   (dataOutNet_o)
  );

  aipPortCtrl upCtrl (
    .clk         (clk),
    .rst         (rst),
    .en_i        (en_i),
    .read_i      (readUp_i),
    .write_i     (writeUp_i),
    .config_i    (configCode_t'(configUp_i)),
    .dataIn_i    (dataInUp_i),
    .status_i    (statusWord),
    .wrBuf       (outBuf.writer),
    .rdBuf       (inBuf.reader),
    .setStatus_o (setStatusUp),
    .dataOut_o   (dataOutUp_o)
  );

  aipDualPortRam inRam (
    .clk (clk),
    .mem (inBuf.ram)
  );

  aipDualPortRam outRam (
    .clk (clk),
    .mem (outBuf.ram)
  );

  // uP raises flags, network acknowledges them
  aipStatus status (
    .clk        (clk),
    .rst        (rst),
    .setUp_i    (setStatusUp),
    .clearNet_i (setStatusNet),
    .upData_i   (dataInUp_i),
    .netData_i  (dataInNet_i),
    .status_o   (statusWord),
    .intReq_o   (intNet_o)
  );

endmodule

`default_nettype wire

/* sim/aipChecker.sv */
`default_nettype none
`include "aipCoprocessor_params.svh"

module aipChecker (
  input  wire                       clk,
  input  wire                       rst,
  input  wire [`AIP_DATA_WIDTH-1:0] dataOutNet_i,
  input  wire [`AIP_DATA_WIDTH-1:0] dataOutUp_i,
  input  wire                       intNet_i,
  output logic                      done_o,
  output int                        errCount_o
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ResetTimeout = 50; // cycles to wait for reset release

  task automatic fetchExpected(input int fd, output bit found, output int side,
                               output int op, output logic [31:0] expVal,
                               output logic [31:0] expInt);
    string       text;
    int          count;
    int          enBit;
    logic [31:0] code;
    logic [31:0] data;
    found = 1'b0;
    while (!found && !$feof(fd)) begin
      text  = "";
      count = $fgets(text, fd);
      count = $sscanf(text, "%h %h %h %h %h %h %h", side, op, enBit, code, data, expVal,
                      expInt);
      found = (count == 7); // comment and blank lines do not parse
    end
  endtask

  initial begin
    int          fd;
    int          side;
    int          op;
    int          lineNo;
    int          waitCycles;
    logic [31:0] expVal;
    logic [31:0] expInt;
    logic        prevInt;
    logic [31:0] got;
    bit          found;
    done_o     = 1'b0;
    errCount_o = 0;
    lineNo     = 0;
    waitCycles = 0;
    fd = $fopen("sim/aipCoprocessor_patterns.txt", "r");
    if (fd == 0) begin
      $display("checker could not open the pattern file");
      errCount_o++;
    end else begin
      // sampled on the falling edge, away from the driving edge
      while (rst !== 1'b1 && waitCycles < ResetTimeout) begin
        @(negedge clk);
        waitCycles++;
      end
      if (rst !== 1'b1) begin
        $display("checker gave up, reset was never released");
        errCount_o++;
      end else begin
        fetchExpected(fd, found, side, op, expVal, expInt);
        while (found) begin
          @(negedge clk);
          if (lineNo > 0 && intNet_i !== prevInt) begin
            $display("FAIL intNet_o: got %h, expected %h after pattern %0d", intNet_i,
                     prevInt, lineNo - 1);
            errCount_o++;
          end
          got = (side == 1) ? dataOutUp_i : dataOutNet_i;
          if (op == 2 && got !== expVal) begin
            $display("FAIL %s: got %h, expected %h at pattern %0d",
                     (side == 1) ? "dataOutUp_o" : "dataOutNet_o", got, expVal, lineNo);
            errCount_o++;
          end
          prevInt = expInt[0];
          lineNo++;
          fetchExpected(fd, found, side, op, expVal, expInt);
        end
        @(negedge clk); // level left by the last pattern
        if (lineNo > 0 && intNet_i !== prevInt) begin
          $display("FAIL intNet_o: got %h, expected %h after pattern %0d", intNet_i,
                   prevInt, lineNo - 1);
          errCount_o++;
        end
      end
      $fclose(fd);
    end
    done_o = 1'b1;
  end

endmodule

`default_nettype wire

/* sim/tbAipCoprocessor.sv */
`default_nettype none
`include "aipCoprocessor_params.svh"

module tbAipCoprocessor;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int DoneTimeout = 200; // cycles allowed for the checker to finish

  logic                         clk;
  logic                         rst;
  logic                         enable;
  logic [`AIP_DATA_WIDTH-1:0]   dataInNet;
  logic [`AIP_CONFIG_WIDTH-1:0] configNet;
  logic                         readNet;
  logic                         writeNet;
  logic [`AIP_DATA_WIDTH-1:0]   dataInUp;
  logic [`AIP_CONFIG_WIDTH-1:0] configUp;
  logic                         readUp;
  logic                         writeUp;
  wire  [`AIP_DATA_WIDTH-1:0]   dataOutNet;
  wire                          intNet;
  wire  [`AIP_DATA_WIDTH-1:0]   dataOutUp;
  wire                          checkDone;
  wire  [31:0]                  checkErrors;
  int                           tbErrors;

  aipCoprocessor UUT (
    .clk          (clk),
    .rst          (rst),
    .en_i         (enable),
    .dataInNet_i  (dataInNet),
    .configNet_i  (configNet),
    .readNet_i    (readNet),
    .writeNet_i   (writeNet),
    .dataOutNet_o (dataOutNet),
    .intNet_o     (intNet),
    .dataInUp_i   (dataInUp),
    .configUp_i   (configUp),
    .readUp_i     (readUp),
    .writeUp_i    (writeUp),
    .dataOutUp_o  (dataOutUp)
  );

  aipChecker scoreboard (
    .clk          (clk),
    .rst          (rst),
    .dataOutNet_i (dataOutNet),
    .dataOutUp_i  (dataOutUp),
    .intNet_i     (intNet),
    .done_o       (checkDone),
    .errCount_o   (checkErrors)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic fetchStimulus(input int fd, output bit found, output int side,
                               output int op, output int enBit,
                               output logic [31:0] code, output logic [31:0] data);
    string       text;
    int          count;
    logic [31:0] expVal;
    logic [31:0] expInt;
    found = 1'b0;
    while (!found && !$feof(fd)) begin
      text  = "";
      count = $fgets(text, fd);
      count = $sscanf(text, "%h %h %h %h %h %h %h", side, op, enBit, code, data, expVal,
                      expInt);
      found = (count == 7);
    end
  endtask

  // one pattern line becomes one cycle of strobes
  task automatic driveAccess(input int side, input int op, input int enBit,
                             input logic [31:0] code, input logic [31:0] data);
    @(posedge clk);
    enable   <= enBit[0];
    readNet  <= (side == 0) && (op == 2);
    writeNet <= (side == 0) && (op == 1);
    readUp   <= (side == 1) && (op == 2);
    writeUp  <= (side == 1) && (op == 1);
    if (op == 0) begin
      dataInNet <= $urandom; // idle gap, no strobe sees it
      dataInUp  <= $urandom;
    end else if (side == 0) begin
      configNet <= code[`AIP_CONFIG_WIDTH-1:0];
      dataInNet <= data;
    end else begin
      configUp <= code[`AIP_CONFIG_WIDTH-1:0];
      dataInUp <= data;
    end
  endtask

  initial begin
    int          fd;
    int          seed;
    int          rndDiscard;
    int          cycles;
    int          side;
    int          op;
    int          enBit;
    logic [31:0] code;
    logic [31:0] data;
    bit          found;
    rst       = 1'b0;
    enable    = 1'b0;
    dataInNet = '0;
    configNet = '0;
    readNet   = 1'b0;
    writeNet  = 1'b0;
    dataInUp  = '0;
    configUp  = '0;
    readUp    = 1'b0;
    writeUp   = 1'b0;
    tbErrors  = 0;
    cycles    = 0;
    seed       = 73;
    rndDiscard = $urandom(seed);
    while (cycles < 2) begin
      @(posedge clk);
      cycles++;
    end
    rst <= 1'b1;
    fd = $fopen("sim/aipCoprocessor_patterns.txt", "r");
    if (fd == 0) begin
      $display("testbench could not open the pattern file");
      tbErrors++;
    end else begin
      fetchStimulus(fd, found, side, op, enBit, code, data);
      while (found) begin
        driveAccess(side, op, enBit, code, data);
        fetchStimulus(fd, found, side, op, enBit, code, data);
      end
      $fclose(fd);
      @(posedge clk);
      enable   <= 1'b0; // quiet bus for the last interrupt sample
      readNet  <= 1'b0;
      writeNet <= 1'b0;
      readUp   <= 1'b0;
      writeUp  <= 1'b0;
    end
    cycles = 0;
    while (checkDone !== 1'b1 && cycles < DoneTimeout) begin
      @(posedge clk);
      cycles++;
    end
    if (checkDone !== 1'b1) begin
      $display("timeout, the checker did not finish the pattern file");
      tbErrors++;
    end
    $display("errors: checker %0d, testbench %0d", checkErrors, tbErrors);
    if (checkErrors == 0 && tbErrors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* aipCoprocessor.f */
+incdir+include
hdl/aipPkg.sv
hdl/aipBufIf.sv
hdl/aipDualPortRam.sv
hdl/aipPortCtrl.sv
hdl/aipStatus.sv
hdl/aipCoprocessor.sv
sim/aipChecker.sv
sim/tbAipCoprocessor.sv

/* sim/aipCoprocessor_patterns.txt */
# side(0 net, 1 uP) op(0 idle, 1 write, 2 read) en code data expect intNet, all hex
# expect is compared on reads, intNet is the level after the line's clock edge
0 1 1 01 00000010 00000000 0
0 1 1 00 11111111 00000000 0
0 1 1 00 22222222 00000000 0
0 1 1 00 33333333 00000000 0
0 1 1 00 44444444 00000000 0
0 0 0 00 00000000 00000000 0
1 1 1 03 00000010 00000000 0
1 2 1 02 00000000 11111111 0
1 2 1 02 00000000 22222222 0
1 2 1 02 00000000 33333333 0
1 2 1 02 00000000 44444444 0
1 1 1 03 00000012 00000000 0
1 2 0 02 00000000 33333333 0
1 2 1 02 00000000 33333333 0
1 2 1 02 00000000 44444444 0
1 1 1 01 00000005 00000000 0
1 1 1 00 55AA55AA 00000000 0
1 1 1 00 0BADF00D 00000000 0
0 1 1 03 00000005 00000000 0
0 2 1 02 00000000 55AA55AA 0
0 2 1 02 00000000 0BADF00D 0
0 2 1 1F 00000000 00004003 0
1 2 1 1F 00000000 00004003 0
0 2 1 0A 00000000 00000000 0
1 2 1 04 00000000 00000000 0
1 1 1 1E 00002A05 00000000 1
0 2 1 1E 00000000 00002A05 1
0 1 1 1E 00000001 00000000 1
0 2 1 1E 00000000 00002A04 1
0 1 1 1E 00000004 00000000 0
0 2 1 1E 00000000 00002A00 0
